//--- source/fifo_ctl_defs.svh
`ifndef FIFO_CTL_DEFS_SVH
`define FIFO_CTL_DEFS_SVH

// ----------------------------------------
// Widths and depths
// ----------------------------------------
`define FIFO_DEPTH      16          // Entries per FIFO, power of two
`define WORD_IN_W       64          // Inbound word from USB bridge
`define WORD_OUT_W      32          // Outbound data toward USB bridge
`define TAG_W           2           // Outbound context tag

// ----------------------------------------
// Magic values
// ----------------------------------------
`define RX_MAGIC        8'h77       // Bits 7..0 of every good inbound word
`define RO_MAGIC        16'hAB89    // Read-only bank +0
`define RW_MAGIC        16'hEFCD    // Read-write bank +0 after reset

// ----------------------------------------
// Identification
// ----------------------------------------
`define VERSION_MAJOR   8'd4
`define VERSION_MINOR   8'd2
`define DEVICE_ID       8'd3

`endif

//--- source/fifo_ctl_pkg.sv
`default_nettype none

`include "fifo_ctl_defs.svh"

package fifo_ctl_pkg;

    // Inbound type field, bits 9..8 of a word
    typedef enum logic [1:0]
    {
        RX_TLP  = 2'b00,    // Straight to PCIe
        RX_CFG  = 2'b01,    // Config path, discarded here
        RX_LOOP = 2'b10,    // Loopback FIFO
        RX_CMD  = 2'b11     // Command FIFO
    } rx_type_t;

    // Outbound entry, tag in the upper bits
    typedef struct packed
    {
        logic [`TAG_W-1:0]      tag;
        logic [`WORD_OUT_W-1:0] data;
    } tx_word_t;

    // Raw command word as received
    // Flags in 13..12, address in 31..16, mask 47..32, value 63..48
    typedef logic [`WORD_IN_W-1:0] cmd_word_t;

endpackage

`default_nettype wire

//--- source/sync_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "fifo_ctl_defs.svh"

module sync_fifo #(
    parameter type payload_t = logic [31:0]
) (
    input  wire         clk,
    input  wire         rst,
    // Write side
    input  wire payload_t i_data,
    input  wire         i_valid,
    output logic        o_full,
    // Read side
    output payload_t    o_data,
    output logic        o_valid,
    input  wire         i_ready
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    payload_t           mem [`FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;          // One extra bit to tell full from empty
    logic               do_wr;
    logic               do_rd;

    assign o_full  = (count == (PTR_W+1)'(`FIFO_DEPTH));
    assign o_valid = (count != '0);     // Registered count, so valid lags write by one cycle
    assign o_data  = mem[rd_ptr];       // Head of queue, read without latency

    assign do_wr = i_valid & ~o_full;   // Word dropped when full
    assign do_rd = o_valid & i_ready;   // Pop on transfer

    // Storage, no reset
    always_ff @(posedge clk)
    begin
        if (do_wr)
            mem[wr_ptr] <= i_data;
    end

    // ----------------------------------------
    // Pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at depth
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                  // Both or neither, level unchanged
            endcase
        end
    end

    // Producer must never push into a full FIFO
    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        i_valid |-> !o_full)
        else $error("sync_fifo: write while full, word lost");

endmodule

`default_nettype wire

//--- source/rx_router.sv
`timescale 1ns/100ps
`default_nettype none

`include "fifo_ctl_defs.svh"

module rx_router import fifo_ctl_pkg::*; (
    input  wire [`WORD_IN_W-1:0]    i_com_data,
    input  wire                     i_com_valid,
    // TLP toward PCIe, no ready
    output logic [`WORD_OUT_W-1:0]  o_tlp_data,
    output logic                    o_tlp_last,
    output logic                    o_tlp_valid,
    // Loopback FIFO write
    output tx_word_t                o_loop_word,
    output logic                    o_loop_valid,
    // Command FIFO write
    output cmd_word_t               o_cmd_word,
    output logic                    o_cmd_valid
);

    logic       magic_ok;
    rx_type_t   rx_type;

    assign magic_ok = (i_com_data[7:0] == `RX_MAGIC);
    assign rx_type  = rx_type_t'(i_com_data[9:8]);

    // Field extraction, valid strobes qualify them
    assign o_tlp_data       = i_com_data[63:32];
    assign o_tlp_last       = i_com_data[10];
    assign o_loop_word.tag  = i_com_data[11:10];    // Loopback tag echoed back
    assign o_loop_word.data = i_com_data[63:32];
    assign o_cmd_word       = i_com_data;           // Decoded in the register file

    // ----------------------------------------
    // Type decode, one strobe per good word
    // ----------------------------------------
    always_comb
    begin
        o_tlp_valid  = 1'b0;
        o_loop_valid = 1'b0;
        o_cmd_valid  = 1'b0;
        if (i_com_valid && magic_ok)                // Bad magic falls through
        begin
            case (rx_type)
                RX_TLP:  o_tlp_valid  = 1'b1;
                RX_LOOP: o_loop_valid = 1'b1;
                RX_CMD:  o_cmd_valid  = 1'b1;
                RX_CFG:  ;                          // No config path on this board
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/cmd_regfile.sv
`timescale 1ns/100ps
`default_nettype none

`include "fifo_ctl_defs.svh"

module cmd_regfile import fifo_ctl_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    // Command FIFO side
    input  wire cmd_word_t i_cmd_word,
    input  wire         i_cmd_valid,
    output logic        o_cmd_ready,
    // Response FIFO side
    output tx_word_t    o_rsp_word,
    output logic        o_rsp_valid,
    input  wire         i_rsp_ready
);

    localparam int RO_BYTES = 24;
    localparam int RW_BYTES = 16;

    // Read-write bank after reset, scratch words zero
    localparam logic [RW_BYTES*8-1:0] RW_RESET =
        {32'h0, 32'h0, 32'(RW_BYTES), 16'h0, `RW_MAGIC};

    logic [63:0]            uptime_q;
    logic [RO_BYTES*8-1:0]  ro_bank;
    logic [RW_BYTES*8-1:0]  rw_bank;
    logic                   rsp_valid_q;
    logic [15:0]            addr;
    logic [14:0]            offs;
    logic [15:0]            mask;
    logic [15:0]            value;
    logic                   cmd_rd;
    logic                   cmd_wr;
    logic                   sel_rw;
    logic                   ro_hit;
    logic                   rw_hit;
    logic [15:0]            ro_val;
    logic [15:0]            rw_val;
    logic [15:0]            rd_val;
    logic [6:0]             wr_base;
    logic                   accept;

    // ----------------------------------------
    // Read-only bank layout
    // ----------------------------------------
    assign ro_bank = {uptime_q,                 // +10 uptime, 64 bit
                      40'h0,                    // +0B slack
                      `DEVICE_ID,               // +0A
                      `VERSION_MINOR,           // +09
                      `VERSION_MAJOR,           // +08
                      32'(RO_BYTES),            // +04 byte count
                      16'h0,                    // +02
                      `RO_MAGIC};               // +00

    // Command field decode
    assign addr    = i_cmd_word[31:16];
    assign offs    = addr[14:0];
    assign sel_rw  = addr[15];                  // High bit picks read-write bank
    assign mask    = {i_cmd_word[39:32], i_cmd_word[47:40]};
    assign value   = {i_cmd_word[55:48], i_cmd_word[63:56]};
    assign cmd_rd  = i_cmd_word[12];
    assign cmd_wr  = i_cmd_word[13];

    // Whole 16-bit register must fit inside the bank
    assign ro_hit  = (offs <= 15'(RO_BYTES - 2));
    assign rw_hit  = (offs <= 15'(RW_BYTES - 2));
    assign ro_val  = ro_hit ? ro_bank[{offs[4:0], 3'b000} +: 16] : 16'h0;
    assign rw_val  = rw_hit ? rw_bank[{offs[3:0], 3'b000} +: 16] : 16'h0;
    assign rd_val  = sel_rw ? rw_val : ro_val;
    assign wr_base = {offs[3:0], 3'b000};

    // Slot free or draining this cycle
    assign o_cmd_ready = ~rsp_valid_q | i_rsp_ready;
    assign accept      = i_cmd_valid & o_cmd_ready;
    assign o_rsp_valid = rsp_valid_q;

    // ----------------------------------------
    // Control state, uptime and write bank
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            uptime_q    <= '0;
            rw_bank     <= RW_RESET;
            rsp_valid_q <= 1'b0;
        end
        else
        begin
            uptime_q <= uptime_q + 1'b1;
            if (rsp_valid_q && i_rsp_ready)
                rsp_valid_q <= 1'b0;            // Response taken by FIFO
            if (accept && cmd_rd)
                rsp_valid_q <= 1'b1;            // New response, overrides drain
            // Read sees old bank, nonblocking update lands after
            if (accept && cmd_wr && sel_rw && rw_hit)
            begin
                for (int i = 0; i < 16; i++)
                begin
                    if (mask[i])
                        rw_bank[wr_base + i] <= value[i];
                end
            end
        end
    end

    // Response payload, address plus byte-swapped register
    always_ff @(posedge clk)
    begin
        if (accept && cmd_rd)
        begin
            o_rsp_word.tag  <= 2'b00;
            o_rsp_word.data <= {addr, rd_val[7:0], rd_val[15:8]};
        end
    end

    // Held response must not change until the FIFO takes it
    a_rsp_stable: assert property (@(posedge clk) disable iff (rst)
        o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp_word))
        else $error("cmd_regfile: response changed while stalled");

endmodule

`default_nettype wire

//--- source/tx_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "fifo_ctl_defs.svh"

module tx_arbiter import fifo_ctl_pkg::*; (
    input  wire                     clk,
    input  wire                     rst,
    // Port 0, upstream TLPs, highest priority
    input  wire [`WORD_OUT_W-1:0]   i_up_data,
    input  wire                     i_up_last,
    input  wire                     i_up_valid,
    output logic                    o_up_ready,
    // Port 1, loopback
    input  wire tx_word_t           i_loop_word,
    input  wire                     i_loop_valid,
    output logic                    o_loop_ready,
    // Port 2, command responses
    input  wire tx_word_t           i_rsp_word,
    input  wire                     i_rsp_valid,
    output logic                    o_rsp_ready,
    // Merged stream toward USB bridge
    output logic [`WORD_OUT_W-1:0]  o_tx_data,
    output logic [`TAG_W-1:0]       o_tx_tag,
    output logic                    o_tx_valid,
    input  wire                     i_tx_ready
);

    typedef enum logic [1:0] {GNT_NONE, GNT_UP, GNT_LOOP, GNT_RSP} grant_t;

    grant_t     gnt;
    grant_t     gnt_q;
    logic       stall_q;        // Last cycle offered but not taken
    logic       pkt_open_q;     // Upstream packet between first and last word
    logic       hold;
    logic       up_xfer;

    assign hold = stall_q | pkt_open_q;

    // ----------------------------------------
    // Grant select, fixed priority
    // ----------------------------------------
    always_comb
    begin
        if (hold)
            gnt = gnt_q;                        // Locked on previous owner
        else if (i_up_valid)
            gnt = GNT_UP;
        else if (i_loop_valid)
            gnt = GNT_LOOP;
        else if (i_rsp_valid)
            gnt = GNT_RSP;
        else
            gnt = GNT_NONE;
    end

    // Output mux
    always_comb
    begin
        o_tx_valid = 1'b0;
        o_tx_data  = i_up_data;
        o_tx_tag   = {1'b0, i_up_last};         // TLP context
        case (gnt)
            GNT_UP:   o_tx_valid = i_up_valid;
            GNT_LOOP:
            begin
                o_tx_valid = i_loop_valid;
                o_tx_data  = i_loop_word.data;
                o_tx_tag   = i_loop_word.tag;
            end
            GNT_RSP:
            begin
                o_tx_valid = i_rsp_valid;
                o_tx_data  = i_rsp_word.data;
                o_tx_tag   = i_rsp_word.tag;
            end
            default:  ;
        endcase
    end

    assign o_up_ready   = (gnt == GNT_UP)   & i_tx_ready;
    assign o_loop_ready = (gnt == GNT_LOOP) & i_tx_ready;
    assign o_rsp_ready  = (gnt == GNT_RSP)  & i_tx_ready;
    assign up_xfer      = o_up_ready & i_up_valid;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            gnt_q      <= GNT_NONE;
            stall_q    <= 1'b0;
            pkt_open_q <= 1'b0;
        end
        else
        begin
            gnt_q   <= gnt;
            stall_q <= o_tx_valid & ~i_tx_ready;
            if (up_xfer)
                pkt_open_q <= ~i_up_last;       // Closes on the last word
        end
    end

    // Sources hold valid and data, arbiter holds the grant
    a_tx_stable: assert property (@(posedge clk) disable iff (rst)
        o_tx_valid && !i_tx_ready |=>
            o_tx_valid && $stable(o_tx_data) && $stable(o_tx_tag))
        else $error("tx_arbiter: outbound word changed while stalled");

endmodule

`default_nettype wire

//--- source/fifo_ctl_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "fifo_ctl_defs.svh"

module fifo_ctl_top import fifo_ctl_pkg::*; (
    input  wire                     clk,
    input  wire                     rst,
    // USB bridge inbound
    input  wire [`WORD_IN_W-1:0]    i_com_data,
    input  wire                     i_com_valid,
    // USB bridge outbound
    output logic [`WORD_OUT_W-1:0]  o_tx_data,
    output logic [`TAG_W-1:0]       o_tx_tag,
    output logic                    o_tx_valid,
    input  wire                     i_tx_ready,
    // TLPs toward PCIe
    output logic [`WORD_OUT_W-1:0]  o_tlp_data,
    output logic                    o_tlp_last,
    output logic                    o_tlp_valid,
    // TLPs from PCIe
    input  wire [`WORD_OUT_W-1:0]   i_up_data,
    input  wire                     i_up_last,
    input  wire                     i_up_valid,
    output logic                    o_up_ready
);

    tx_word_t   loop_in_word;
    logic       loop_in_valid;
    tx_word_t   loop_word;
    logic       loop_valid;
    logic       loop_ready;
    cmd_word_t  cmd_in_word;
    logic       cmd_in_valid;
    cmd_word_t  cmd_word;
    logic       cmd_valid;
    logic       cmd_ready;
    tx_word_t   rsp_in_word;
    logic       rsp_in_valid;
    logic       rsp_full;
    tx_word_t   rsp_word;
    logic       rsp_valid;
    logic       rsp_ready;

    // ----------------------------------------
    // Inbound side
    // ----------------------------------------
    rx_router i_rx_router (
        .i_com_data   (i_com_data),
        .i_com_valid  (i_com_valid),
        .o_tlp_data   (o_tlp_data),
        .o_tlp_last   (o_tlp_last),
        .o_tlp_valid  (o_tlp_valid),
        .o_loop_word  (loop_in_word),
        .o_loop_valid (loop_in_valid),
        .o_cmd_word   (cmd_in_word),
        .o_cmd_valid  (cmd_in_valid)
    );

    sync_fifo #(.payload_t(tx_word_t)) i_fifo_loop (
        .clk     (clk),
        .rst     (rst),
        .i_data  (loop_in_word),
        .i_valid (loop_in_valid),
        .o_full  (),                    // No ready on inbound port
        .o_data  (loop_word),
        .o_valid (loop_valid),
        .i_ready (loop_ready)
    );

    sync_fifo #(.payload_t(cmd_word_t)) i_fifo_cmd (
        .clk     (clk),
        .rst     (rst),
        .i_data  (cmd_in_word),
        .i_valid (cmd_in_valid),
        .o_full  (),
        .o_data  (cmd_word),
        .o_valid (cmd_valid),
        .i_ready (cmd_ready)
    );

    // Register file and its response queue
    cmd_regfile i_cmd_regfile (
        .clk         (clk),
        .rst         (rst),
        .i_cmd_word  (cmd_word),
        .i_cmd_valid (cmd_valid),
        .o_cmd_ready (cmd_ready),
        .o_rsp_word  (rsp_in_word),
        .o_rsp_valid (rsp_in_valid),
        .i_rsp_ready (~rsp_full)        // Back-pressure from response FIFO
    );

    sync_fifo #(.payload_t(tx_word_t)) i_fifo_rsp (
        .clk     (clk),
        .rst     (rst),
        .i_data  (rsp_in_word),
        .i_valid (rsp_in_valid),
        .o_full  (rsp_full),
        .o_data  (rsp_word),
        .o_valid (rsp_valid),
        .i_ready (rsp_ready)
    );

    // ----------------------------------------
    // Outbound merge
    // ----------------------------------------
    tx_arbiter i_tx_arbiter (
        .clk          (clk),
        .rst          (rst),
        .i_up_data    (i_up_data),
        .i_up_last    (i_up_last),
        .i_up_valid   (i_up_valid),
        .o_up_ready   (o_up_ready),
        .i_loop_word  (loop_word),
        .i_loop_valid (loop_valid),
        .o_loop_ready (loop_ready),
        .i_rsp_word   (rsp_word),
        .i_rsp_valid  (rsp_valid),
        .o_rsp_ready  (rsp_ready),
        .o_tx_data    (o_tx_data),
        .o_tx_tag     (o_tx_tag),
        .o_tx_valid   (o_tx_valid),
        .i_tx_ready   (i_tx_ready)
    );

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD  = 50,    // 100 ns period
    parameter int RESET_CYCLES = 3
) (
    output logic o_clk,
    output logic o_rst
);

    initial
    begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    // Synchronous reset, released on a rising edge
    initial
    begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- verif/tb_fifo_ctl.sv
`timescale 1ns/100ps
`default_nettype none

`include "fifo_ctl_defs.svh"

module tb_fifo_ctl;

    localparam int MAX_CYCLES = 5000;   // Tests need about 1500
    localparam int LOOP_WORDS = 12;
    localparam int PKT_WORDS  = 4;

    logic                   clk;
    logic                   rst;
    logic [`WORD_IN_W-1:0]  i_com_data;
    logic                   i_com_valid;
    logic [`WORD_OUT_W-1:0] o_tx_data;
    logic [`TAG_W-1:0]      o_tx_tag;
    logic                   o_tx_valid;
    logic                   i_tx_ready;
    logic [`WORD_OUT_W-1:0] o_tlp_data;
    logic                   o_tlp_last;
    logic                   o_tlp_valid;
    logic [`WORD_OUT_W-1:0] i_up_data;
    logic                   i_up_last;
    logic                   i_up_valid;
    logic                   o_up_ready;

    logic [67:0]    exp_q [$];          // {mask, tag + data} in output order
    logic [67:0]    head_entry;
    logic [67:0]    mon_entry;
    logic [33:0]    exp_head;
    logic [33:0]    exp_mask;
    logic           exp_empty;
    logic [15:0]    uptime_q [$];       // Uptime low words as read back
    logic [32:0]    tlp_exp;            // {last, data} due on PCIe side
    logic           tlp_exp_on;
    logic           rand_ready;
    logic [31:0]    up_words [PKT_WORDS];
    logic [31:0]    rnd_data;
    logic [1:0]     rnd_tag;
    logic [15:0]    merged;
    logic [63:0]    word;
    int             cycle_cnt;
    string          test_name;

    tb_clock i_tb_clock (.o_clk(clk), .o_rst(rst));

    fifo_ctl_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .i_com_data  (i_com_data),
        .i_com_valid (i_com_valid),
        .o_tx_data   (o_tx_data),
        .o_tx_tag    (o_tx_tag),
        .o_tx_valid  (o_tx_valid),
        .i_tx_ready  (i_tx_ready),
        .o_tlp_data  (o_tlp_data),
        .o_tlp_last  (o_tlp_last),
        .o_tlp_valid (o_tlp_valid),
        .i_up_data   (i_up_data),
        .i_up_last   (i_up_last),
        .i_up_valid  (i_up_valid),
        .o_up_ready  (o_up_ready)
    );

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic logic [63:0] make_loop_word(input logic [1:0] tag, input logic [31:0] data);
        return {data, 20'h0, tag, 2'b10, `RX_MAGIC};
    endfunction

    function automatic logic [63:0] make_tlp_word(input logic last, input logic [31:0] data);
        return {data, 21'h0, last, 2'b00, `RX_MAGIC};
    endfunction

    // Mask and value travel low byte first inside each half
    function automatic logic [63:0] make_cmd_word(input logic rd, input logic wr,
        input logic [15:0] addr, input logic [15:0] mask, input logic [15:0] value);
        return {value[7:0], value[15:8], mask[7:0], mask[15:8], addr,
                2'b00, wr, rd, 2'b00, 2'b11, `RX_MAGIC};
    endfunction

    // Read response, register byte-swapped under its address
    function automatic logic [33:0] rsp_entry(input logic [15:0] addr, input logic [15:0] regv);
        return {2'b00, addr, regv[7:0], regv[15:8]};
    endfunction

    task automatic push_exp(input logic [33:0] value, input logic [33:0] mask);
        exp_q.push_back({mask, value});
    endtask

    task automatic send_com(input logic [63:0] w, input logic tlp_on);
        @(posedge clk);
        i_com_data  <= w;
        i_com_valid <= 1'b1;
        tlp_exp     <= {w[10], w[63:32]};
        tlp_exp_on  <= tlp_on;
        @(posedge clk);
        i_com_valid <= 1'b0;
        tlp_exp_on  <= 1'b0;
    endtask

    // Upstream packet, valid held until each handshake
    // One idle cycle after every word, grant must stay on the open packet
    task automatic send_up_packet();
        @(posedge clk);
        for (int i = 0; i < PKT_WORDS; i++)
        begin
            i_up_data  <= up_words[i];
            i_up_last  <= (i == PKT_WORDS - 1);
            i_up_valid <= 1'b1;
            @(posedge clk);
            while (!o_up_ready)
                @(posedge clk);
            i_up_valid <= 1'b0;
            @(posedge clk);
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);
    endtask

    // ----------------------------------------
    // Expected head, refreshed off the active edge
    // ----------------------------------------
    always @(negedge clk)
    begin
        if (exp_q.size() == 0)
        begin
            exp_empty <= 1'b1;
            exp_head  <= '0;
            exp_mask  <= '0;
        end
        else
        begin
            head_entry = exp_q[0];
            exp_empty <= 1'b0;
            exp_mask  <= head_entry[67:34];
            exp_head  <= head_entry[33:0];
        end
    end

    // Pop on each outbound transfer
    always @(posedge clk)
    begin
        if (!rst && o_tx_valid && i_tx_ready && exp_q.size() != 0)
        begin
            mon_entry = exp_q[0];
            if (mon_entry[49:34] == 16'h0000)   // Low half masked, uptime read
                uptime_q.push_back({o_tx_data[7:0], o_tx_data[15:8]});
            void'(exp_q.pop_front());
        end
    end

    // Random stalls from the USB bridge side
    always @(posedge clk)
    begin
        if (rand_ready)
            i_tx_ready <= ($urandom % 4) != 0;
        else
            i_tx_ready <= 1'b0;
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
            fail_run("Timeout, outbound traffic never finished");
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_tx_expected: assert property (@(posedge clk) disable iff (rst)
        o_tx_valid && i_tx_ready |-> !exp_empty)
        else fail_run($sformatf("Unexpected outbound word in %s", test_name));

    a_tx_match: assert property (@(posedge clk) disable iff (rst)
        o_tx_valid && i_tx_ready && !exp_empty |->
            ((({o_tx_tag, o_tx_data} ^ exp_head) & exp_mask) == '0))
        else fail_run($sformatf("CHECK FAILED %s expected %h actual %h", test_name,
            $sampled(exp_head), $sampled({o_tx_tag, o_tx_data})));

    // Offered word stays put until the bridge takes it
    a_tx_hold: assert property (@(posedge clk) disable iff (rst)
        o_tx_valid && !i_tx_ready |=>
            o_tx_valid && $stable({o_tx_tag, o_tx_data}))
        else fail_run($sformatf("Outbound word changed during a stall in %s", test_name));

    a_tlp_route: assert property (@(posedge clk) disable iff (rst)
        (o_tlp_valid == tlp_exp_on) && (!tlp_exp_on || {o_tlp_last, o_tlp_data} == tlp_exp))
        else fail_run($sformatf("CHECK FAILED %s expected %h actual %h", test_name,
            $sampled({tlp_exp_on, tlp_exp}), $sampled({o_tlp_valid, o_tlp_last, o_tlp_data})));

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial
    begin
        void'($urandom(28438));
        i_com_data  = '0;
        i_com_valid = 1'b0;
        i_tx_ready  = 1'b0;
        i_up_data   = '0;
        i_up_last   = 1'b0;
        i_up_valid  = 1'b0;
        tlp_exp     = '0;
        tlp_exp_on  = 1'b0;
        rand_ready  = 1'b1;
        exp_empty   = 1'b1;
        exp_head    = '0;
        exp_mask    = '0;
        cycle_cnt   = 0;
        test_name   = "reset";
        @(posedge clk);
        while (rst)
            @(posedge clk);

        test_name = "loopback";
        for (int i = 0; i < LOOP_WORDS; i++)
        begin
            rnd_data = $urandom;
            rnd_tag  = 2'($urandom);
            push_exp({rnd_tag, rnd_data}, '1);
            send_com(make_loop_word(rnd_tag, rnd_data), 1'b0);
        end
        wait_drain();

        test_name = "tlp_routing";
        send_com(make_tlp_word(1'b0, 32'h1234_5678), 1'b1);
        send_com(make_tlp_word(1'b1, 32'h9ABC_DEF0), 1'b1);
        word      = make_loop_word(2'b01, 32'hDEAD_BEEF);
        word[7:0] = 8'h76;                          // Bad magic
        send_com(word, 1'b0);
        word      = make_tlp_word(1'b1, 32'h0BAD_0BAD);
        word[9:8] = 2'b01;                          // CFG type
        send_com(word, 1'b0);
        repeat (20) @(posedge clk);

        test_name = "reg_reads";
        push_exp(rsp_entry(16'h0000, 16'hAB89), '1);
        send_com(make_cmd_word(1'b1, 1'b0, 16'h0000, 16'h0, 16'h0), 1'b0);
        push_exp(rsp_entry(16'h0008, 16'h0204), '1);  // Major at +8, minor at +9
        send_com(make_cmd_word(1'b1, 1'b0, 16'h0008, 16'h0, 16'h0), 1'b0);
        push_exp(rsp_entry(16'h0018, 16'h0000), '1);  // Past the 24-byte bank
        send_com(make_cmd_word(1'b1, 1'b0, 16'h0018, 16'h0, 16'h0), 1'b0);
        push_exp(rsp_entry(16'h8000, 16'hEFCD), '1);
        send_com(make_cmd_word(1'b1, 1'b0, 16'h8000, 16'h0, 16'h0), 1'b0);
        wait_drain();

        test_name = "masked_write";
        merged = (16'h1234 & 16'h0FF0) | (16'h0000 & ~16'h0FF0);
        send_com(make_cmd_word(1'b0, 1'b1, 16'h8008, 16'h0FF0, 16'h1234), 1'b0);
        push_exp(rsp_entry(16'h8008, merged), '1);
        send_com(make_cmd_word(1'b1, 1'b0, 16'h8008, 16'h0, 16'h0), 1'b0);
        merged = (16'hABCD & 16'hF00F) | (merged & ~16'hF00F);  // Keeps bits of the first write
        send_com(make_cmd_word(1'b0, 1'b1, 16'h8008, 16'hF00F, 16'hABCD), 1'b0);
        push_exp(rsp_entry(16'h8008, merged), '1);
        send_com(make_cmd_word(1'b1, 1'b0, 16'h8008, 16'h0, 16'h0), 1'b0);
        push_exp(rsp_entry(16'h800C, 16'h0000), '1);  // Read before write
        send_com(make_cmd_word(1'b1, 1'b1, 16'h800C, 16'hFFFF, 16'hBEEF), 1'b0);
        push_exp(rsp_entry(16'h800C, 16'hBEEF), '1);
        send_com(make_cmd_word(1'b1, 1'b0, 16'h800C, 16'h0, 16'h0), 1'b0);
        wait_drain();

        // Packet first, then loopback queued behind it
        test_name = "arbitration";
        for (int i = 0; i < PKT_WORDS; i++)
        begin
            up_words[i] = $urandom;
            push_exp({1'b0, i == PKT_WORDS - 1, up_words[i]}, '1);
        end
        rand_ready <= 1'b0;
        fork
            send_up_packet();
            begin
                repeat (2) @(posedge clk);
                for (int i = 0; i < 6; i++)
                begin
                    rnd_data = $urandom;
                    rnd_tag  = 2'($urandom);
                    push_exp({rnd_tag, rnd_data}, '1);
                    send_com(make_loop_word(rnd_tag, rnd_data), 1'b0);
                end
                repeat (3) @(posedge clk);
                rand_ready <= 1'b1;
            end
        join
        wait_drain();

        test_name = "uptime";
        push_exp(rsp_entry(16'h0010, 16'h0000), {2'b11, 16'hFFFF, 16'h0000});
        send_com(make_cmd_word(1'b1, 1'b0, 16'h0010, 16'h0, 16'h0), 1'b0);
        wait_drain();
        repeat (50) @(posedge clk);
        push_exp(rsp_entry(16'h0010, 16'h0000), {2'b11, 16'hFFFF, 16'h0000});
        send_com(make_cmd_word(1'b1, 1'b0, 16'h0010, 16'h0, 16'h0), 1'b0);
        wait_drain();
        a_uptime: assert (uptime_q.size() == 2 && uptime_q[1] > uptime_q[0])
            else fail_run($sformatf("CHECK FAILED %s expected above %h actual %h",
                test_name, uptime_q[0], uptime_q[uptime_q.size() - 1]));

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+source
source/fifo_ctl_pkg.sv
source/sync_fifo.sv
source/rx_router.sv
source/cmd_regfile.sv
source/tx_arbiter.sv
source/fifo_ctl_top.sv
verif/tb_clock.sv
verif/tb_fifo_ctl.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    -f build.f --top-module tb_fifo_ctl --Mdir obj_dir &&
./obj_dir/Vtb_fifo_ctl ||
{
    echo "Simulation build or run failed"
    exit 1
}
